//--- Bender.yml
package:
  name: bus_datapath

sources:
  - include_dirs:
      - src
    files:
      - src/datapath_pkg.sv
      - src/gpr_if.sv
      - src/register_file.sv
      - src/special_regs.sv
      - src/mdr_unit.sv
      - src/alu.sv
      - src/bus_driver.sv
      - src/bus_datapath.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_datapath.sv

//--- list.f
+incdir+src
src/datapath_pkg.sv
src/gpr_if.sv
src/register_file.sv
src/special_regs.sv
src/mdr_unit.sv
src/alu.sv
src/bus_driver.sv
src/bus_datapath.sv
verification/tb_clock_gen.sv
verification/tb_datapath.sv

//--- src/alu.sv
`timescale 1ns/1ns
`include "datapath_defines.svh"

module alu import datapath_pkg::*; (
	input  logic [`WORD_WIDTH-1:0] y,
	input  logic [`WORD_WIDTH-1:0] b,
	input  alu_op_t                opcode,
	input  logic                   inc_pc,
	output z_word_t                result
);

	logic signed [`WORD_WIDTH-1:0]   ys;
	logic signed [`WORD_WIDTH-1:0]   bs;
	logic        [4:0]               amt;

	assign ys  = y;
	assign bs  = b;
	assign amt = b[4:0]; // Shift distance comes from the bus operand

	always_comb begin
		result.full = '0;
		if (inc_pc) begin
			// PC increment overrides whatever opcode is applied
			result.half.lo = b + 1'b1;
		end else begin
			case (opcode)
				op_add: result.half.lo = y + b;
				op_sub: result.half.lo = y - b;
				op_and: result.half.lo = y & b;
				op_or:  result.half.lo = y | b;
				op_shr: result.half.lo = y >> amt;
				op_shl: result.half.lo = y << amt;
				op_ror: begin
					result.half.lo = y >> amt | y << (`WORD_WIDTH - amt);
				end
				op_rol: begin
					result.half.lo = y << amt | y >> (`WORD_WIDTH - amt);
				end
				op_mul: result.full = ys * bs; // Full signed product
				op_div: begin
					if (b == '0) begin
						result.half.hi = y;
						result.half.lo = '1;
					end else begin
						result.half.hi = ys % bs; // Takes the sign of the dividend
						result.half.lo = ys / bs;
					end
				end
				op_neg: result.half.lo = -b;
				op_not: result.half.lo = ~b;
				default: result.full = '0;
			endcase
		end
	end

endmodule

//--- src/bus_datapath.sv
`timescale 1ns/1ns
`include "datapath_defines.svh"

module bus_datapath import datapath_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`WORD_WIDTH-1:0] mem_data_in,
	input  logic [`WORD_WIDTH-1:0] in_port,
	input  logic                   read,
	input  logic                   inc_pc,
	input  logic [`NUM_GPR-1:0]    gpr_enable,
	input  logic [`NUM_GPR-1:0]    gpr_out,
	input  logic                   pc_enable,
	input  logic                   z_enable,
	input  logic                   mdr_enable,
	input  logic                   y_enable,
	input  logic                   hi_enable,
	input  logic                   lo_enable,
	input  logic                   hi_out,
	input  logic                   lo_out,
	input  logic                   zhi_out,
	input  logic                   zlo_out,
	input  logic                   pc_out,
	input  logic                   mdr_out,
	input  logic                   inport_out,
	input  logic [4:0]             opcode,
	output logic [`WORD_WIDTH-1:0] bus
);

	logic [`WORD_WIDTH-1:0] hi_q;
	logic [`WORD_WIDTH-1:0] lo_q;
	logic [`WORD_WIDTH-1:0] pc_q;
	logic [`WORD_WIDTH-1:0] y_q;
	logic [`WORD_WIDTH-1:0] zhi_q;
	logic [`WORD_WIDTH-1:0] zlo_q;
	logic [`WORD_WIDTH-1:0] inport_q;
	logic [`WORD_WIDTH-1:0] mdr_q;
	z_word_t                alu_result;

	gpr_if gpr ();

	assign gpr.en      = gpr_enable;
	assign gpr.out_sel = gpr_out;

	register_file register_file_i (.clk(clk), .rst(rst), .gpr(gpr.rf));

	special_regs special_regs_i (
		.clk(clk), .rst(rst), .bus(bus), .alu_result(alu_result),
		.hi_enable(hi_enable), .lo_enable(lo_enable), .pc_enable(pc_enable),
		.y_enable(y_enable), .z_enable(z_enable), .in_port(in_port),
		.hi_q(hi_q), .lo_q(lo_q), .pc_q(pc_q), .y_q(y_q),
		.zhi_q(zhi_q), .zlo_q(zlo_q), .inport_q(inport_q)
	);

	mdr_unit mdr_unit_i (
		.clk(clk), .rst(rst), .mdr_enable(mdr_enable), .read(read),
		.bus(bus), .mem_data_in(mem_data_in), .mdr_q(mdr_q)
	);

	// Y is the stored operand, the bus is the live one
	alu alu_i (.y(y_q), .b(bus), .opcode(alu_op_t'(opcode)), .inc_pc(inc_pc),
		.result(alu_result));

	bus_driver bus_driver_i (
		.clk(clk), .rst(rst), .gpr(gpr.drv),
		.hi_out(hi_out), .lo_out(lo_out), .zhi_out(zhi_out), .zlo_out(zlo_out),
		.pc_out(pc_out), .mdr_out(mdr_out), .inport_out(inport_out),
		.hi_q(hi_q), .lo_q(lo_q), .zhi_q(zhi_q), .zlo_q(zlo_q),
		.pc_q(pc_q), .mdr_q(mdr_q), .inport_q(inport_q), .bus(bus)
	);

endmodule

//--- src/bus_driver.sv
`timescale 1ns/1ns
`include "datapath_defines.svh"

module bus_driver import datapath_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	gpr_if.drv                     gpr,
	input  logic                   hi_out,
	input  logic                   lo_out,
	input  logic                   zhi_out,
	input  logic                   zlo_out,
	input  logic                   pc_out,
	input  logic                   mdr_out,
	input  logic                   inport_out,
	input  logic [`WORD_WIDTH-1:0] hi_q,
	input  logic [`WORD_WIDTH-1:0] lo_q,
	input  logic [`WORD_WIDTH-1:0] zhi_q,
	input  logic [`WORD_WIDTH-1:0] zlo_q,
	input  logic [`WORD_WIDTH-1:0] pc_q,
	input  logic [`WORD_WIDTH-1:0] mdr_q,
	input  logic [`WORD_WIDTH-1:0] inport_q,
	output logic [`WORD_WIDTH-1:0] bus
);

	localparam int strobe_count = `NUM_BUS_SRC - 1; // Every code except none

	logic [strobe_count-1:0] strobes;
	bus_src_t                src;

	// Bit i selects source code i + 1
	assign strobes = {inport_out, mdr_out, pc_out, zlo_out, zhi_out, lo_out, hi_out,
		gpr.rd_valid};

	always_comb begin
		src = src_none;
		for (int i = 0; i < strobe_count; i++) begin
			if (strobes[i]) begin
				src = bus_src_t'(i + 1);
			end
		end
	end

	always_comb begin
		case (src)
			src_gpr:    bus = gpr.rd_data;
			src_hi:     bus = hi_q;
			src_lo:     bus = lo_q;
			src_zhi:    bus = zhi_q;
			src_zlo:    bus = zlo_q;
			src_pc:     bus = pc_q;
			src_mdr:    bus = mdr_q;
			src_inport: bus = inport_q;
			default:    bus = '0; // Idle bus reads zero
		endcase
	end

	assign gpr.wr_data = bus;

	// Register file select and the special strobes share one bus
	a_one_source: assert property (
		@(posedge clk) disable iff (rst) $onehot0(strobes)
	) else $error("More than one bus source active: %b", strobes);

endmodule

//--- src/datapath_defines.svh
`ifndef DATAPATH_DEFINES_SVH
`define DATAPATH_DEFINES_SVH

// Width of every register and of the shared bus
`define WORD_WIDTH 32

// General purpose registers r0 to r15
`define NUM_GPR 16

// Eight real sources plus the idle code
`define NUM_BUS_SRC 9

`endif

//--- src/datapath_pkg.sv
`include "datapath_defines.svh"

package datapath_pkg;

	typedef enum logic [4:0] {
		op_add = 5'd0,
		op_sub = 5'd1,
		op_and = 5'd2,
		op_or  = 5'd3,
		op_shr = 5'd4,
		op_shl = 5'd5,
		op_ror = 5'd6,
		op_rol = 5'd7,
		op_mul = 5'd8,
		op_div = 5'd9,
		op_neg = 5'd10,
		op_not = 5'd11
	} alu_op_t;

	// Order matches the strobe vector in bus_driver, offset by one
	typedef enum logic [3:0] {
		src_none   = 4'd0,
		src_gpr    = 4'd1,
		src_hi     = 4'd2,
		src_lo     = 4'd3,
		src_zhi    = 4'd4,
		src_zlo    = 4'd5,
		src_pc     = 4'd6,
		src_mdr    = 4'd7,
		src_inport = 4'd8
	} bus_src_t;

	typedef struct packed {
		logic [`WORD_WIDTH-1:0] hi; // Remainder for div
		logic [`WORD_WIDTH-1:0] lo; // Quotient for div
	} z_halves_t;

	// Mul writes the whole product, everything else fills the halves
	typedef union packed {
		logic [2*`WORD_WIDTH-1:0] full;
		z_halves_t                half;
	} z_word_t;

endpackage

//--- src/gpr_if.sv
`timescale 1ns/1ns
`include "datapath_defines.svh"

interface gpr_if;
	logic [`NUM_GPR-1:0]    en;      // Load enable per register
	logic [`NUM_GPR-1:0]    out_sel; // One-hot read select
	logic [`WORD_WIDTH-1:0] wr_data; // The bus
	logic [`WORD_WIDTH-1:0] rd_data;
	logic                   rd_valid;

	modport rf (
		input  en, out_sel, wr_data,
		output rd_data, rd_valid
	);

	modport drv (
		input  rd_data, rd_valid,
		output wr_data
	);
endinterface

//--- src/mdr_unit.sv
`timescale 1ns/1ns
`include "datapath_defines.svh"

module mdr_unit (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   mdr_enable,
	input  logic                   read,
	input  logic [`WORD_WIDTH-1:0] bus,
	input  logic [`WORD_WIDTH-1:0] mem_data_in,
	output logic [`WORD_WIDTH-1:0] mdr_q
);

	logic [`WORD_WIDTH-1:0] mdr_d;

	// Memory side wins while a read is in progress
	assign mdr_d = read ? mem_data_in : bus;

	always_ff @(posedge clk) begin
		if (rst) begin
			mdr_q <= '0;
		end else if (mdr_enable) begin
			mdr_q <= mdr_d;
		end
	end

endmodule

//--- src/register_file.sv
`timescale 1ns/1ns
`include "datapath_defines.svh"

module register_file (
	input logic clk,
	input logic rst,
	gpr_if.rf   gpr
);

	logic [`WORD_WIDTH-1:0] regs [`NUM_GPR];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `NUM_GPR; i++) begin
				regs[i] <= '0;
			end
		end else begin
			// Several registers may load the same bus word at once
			for (int i = 0; i < `NUM_GPR; i++) begin
				if (gpr.en[i]) begin
					regs[i] <= gpr.wr_data;
				end
			end
		end
	end

	// OR of the selected words, which is exact while out_sel stays one-hot
	always_comb begin
		gpr.rd_data = '0;
		for (int i = 0; i < `NUM_GPR; i++) begin
			if (gpr.out_sel[i]) begin
				gpr.rd_data = gpr.rd_data | regs[i];
			end
		end
	end

	assign gpr.rd_valid = |gpr.out_sel;

	// The control side must never open two registers onto the bus together
	a_out_sel_onehot: assert property (
		@(posedge clk) disable iff (rst) $onehot0(gpr.out_sel)
	) else $error("Register read select is not one-hot: %b", gpr.out_sel);

endmodule

//--- src/special_regs.sv
`timescale 1ns/1ns
`include "datapath_defines.svh"

module special_regs import datapath_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`WORD_WIDTH-1:0] bus,
	input  z_word_t                alu_result,
	input  logic                   hi_enable,
	input  logic                   lo_enable,
	input  logic                   pc_enable,
	input  logic                   y_enable,
	input  logic                   z_enable,
	input  logic [`WORD_WIDTH-1:0] in_port,
	output logic [`WORD_WIDTH-1:0] hi_q,
	output logic [`WORD_WIDTH-1:0] lo_q,
	output logic [`WORD_WIDTH-1:0] pc_q,
	output logic [`WORD_WIDTH-1:0] y_q,
	output logic [`WORD_WIDTH-1:0] zhi_q,
	output logic [`WORD_WIDTH-1:0] zlo_q,
	output logic [`WORD_WIDTH-1:0] inport_q
);

	z_word_t z_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			hi_q     <= '0;
			lo_q     <= '0;
			pc_q     <= '0;
			y_q      <= '0;
			z_q      <= '0;
			inport_q <= '0;
		end else begin
			if (hi_enable) begin
				hi_q <= bus;
			end
			if (lo_enable) begin
				lo_q <= bus;
			end
			if (pc_enable) begin
				pc_q <= bus;
			end
			if (y_enable) begin
				y_q <= bus; // Y holds the left ALU operand
			end
			if (z_enable) begin
				z_q <= alu_result;
			end
			// The input port is sampled every cycle
			inport_q <= in_port;
		end
	end

	assign zhi_q = z_q.half.hi;
	assign zlo_q = z_q.half.lo;

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
	parameter int period       = 10,
	parameter int reset_cycles = 8
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// Reset leaves on a rising edge, like every other stimulus
	initial begin
		rst = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

//--- verification/tb_datapath.sv
`timescale 1ns/1ns
`include "datapath_defines.svh"

module tb_datapath import datapath_pkg::*; ();

	localparam int clk_period  = 10;
	localparam int test_cycles = 450; // Upper bound on the cycles of all six tests
	localparam int margin_ns   = 1000;

	typedef enum {to_none, to_hi, to_lo, to_pc, to_y, to_mdr} dest_t;

	logic clk, rst, read, inc_pc;
	logic [`WORD_WIDTH-1:0] mem_data_in, in_port, bus;
	logic [`NUM_GPR-1:0] gpr_enable, gpr_out;
	logic pc_enable, z_enable, mdr_enable, y_enable, hi_enable, lo_enable;
	logic hi_out, lo_out, zhi_out, zlo_out, pc_out, mdr_out, inport_out;
	logic [4:0] opcode;
	logic [15:0] lfsr_state = 16'd17214;
	int error_count = 0;
	int failed_tests = 0;
	int test_count = 0;

	tb_clock_gen #(.period(clk_period), .reset_cycles(8)) clock_gen_i (.clk(clk), .rst(rst));

	bus_datapath dut_i (.*);

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_word(output logic [31:0] w);
		for (int i = 0; i < 32; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			w = {w[30:0], lfsr_state[0]};
		end
	endtask

	function automatic logic [31:0] rotate_right(input logic [31:0] v, input int n);
		logic [31:0] r;
		r = v;
		repeat (n) r = {r[0], r[31:1]};
		return r;
	endfunction

	function automatic logic [31:0] rotate_left(input logic [31:0] v, input int n);
		logic [31:0] r;
		r = v;
		repeat (n) r = {r[30:0], r[31]};
		return r;
	endfunction

	// Divide magnitudes, then the quotient takes the sign product and the remainder the dividend sign
	function automatic logic [63:0] signed_divide(input logic [31:0] y, input logic [31:0] b);
		logic [31:0] ya, ba, q, r;
		if (b == 32'h0) return {y, 32'hffff_ffff};
		ya = y[31] ? -y : y;
		ba = b[31] ? -b : b;
		q = ya / ba;
		r = ya % ba;
		if (y[31] != b[31]) q = -q;
		if (y[31]) r = -r;
		return {r, q};
	endfunction

	function automatic logic [63:0] expected_z(input alu_op_t op, input logic [31:0] y,
		input logic [31:0] b);
		logic [63:0] ye, be;
		ye = {{32{y[31]}}, y};
		be = {{32{b[31]}}, b};
		case (op)
			op_add:  return {32'h0, y + b};
			op_sub:  return {32'h0, y - b};
			op_and:  return {32'h0, y & b};
			op_or:   return {32'h0, y | b};
			op_shr:  return {32'h0, y >> b[4:0]};
			op_shl:  return {32'h0, y << b[4:0]};
			op_ror:  return {32'h0, rotate_right(y, b[4:0])};
			op_rol:  return {32'h0, rotate_left(y, b[4:0])};
			op_mul:  return ye * be; // Low 64 bits of the sign-extended product
			op_div:  return signed_divide(y, b);
			op_neg:  return {32'h0, -b};
			op_not:  return {32'h0, ~b};
			default: return 64'h0;
		endcase
	endfunction

	task automatic init_inputs();
		{mem_data_in, in_port, read, inc_pc, gpr_enable, gpr_out, opcode} = '0;
		{pc_enable, z_enable, mdr_enable, y_enable, hi_enable, lo_enable} = '0;
		{hi_out, lo_out, zhi_out, zlo_out, pc_out, mdr_out, inport_out} = '0;
	endtask

	// Every cycle starts with all strobes low, the caller raises what it needs
	task automatic begin_cycle();
		@(posedge clk);
		{read, inc_pc, gpr_enable, gpr_out, opcode} <= '0;
		{pc_enable, z_enable, mdr_enable, y_enable, hi_enable, lo_enable} <= '0;
		{hi_out, lo_out, zhi_out, zlo_out, pc_out, mdr_out, inport_out} <= '0;
	endtask

	task automatic set_src(input bus_src_t s, input int idx);
		case (s)
			src_gpr:    gpr_out <= `NUM_GPR'(1) << idx;
			src_hi:     hi_out <= 1'b1;
			src_lo:     lo_out <= 1'b1;
			src_zhi:    zhi_out <= 1'b1;
			src_zlo:    zlo_out <= 1'b1;
			src_pc:     pc_out <= 1'b1;
			src_mdr:    mdr_out <= 1'b1;
			src_inport: inport_out <= 1'b1;
			default:    ;
		endcase
	endtask

	task automatic set_dest(input dest_t d);
		case (d)
			to_hi:   hi_enable <= 1'b1;
			to_lo:   lo_enable <= 1'b1;
			to_pc:   pc_enable <= 1'b1;
			to_y:    y_enable <= 1'b1;
			to_mdr:  mdr_enable <= 1'b1;
			default: ;
		endcase
	endtask

	task automatic transfer(input bus_src_t s, input int idx, input dest_t d);
		begin_cycle();
		set_src(s, idx);
		set_dest(d);
	endtask

	// The bus settles well before the falling edge
	task automatic read_bus(input bus_src_t s, input int idx, output logic [31:0] v);
		begin_cycle();
		set_src(s, idx);
		@(negedge clk);
		v = bus;
	endtask

	task automatic load_gpr(input int idx, input logic [31:0] v);
		begin_cycle();
		in_port <= v;
		transfer(src_inport, 0, to_none);
		gpr_enable <= `NUM_GPR'(1) << idx;
	endtask

	task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
			error_count++;
		end
	endtask

	task automatic check_source(input string what, input bus_src_t s, input int idx,
		input logic [31:0] exp);
		logic [31:0] v;
		read_bus(s, idx, v);
		check_word(what, v, exp);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("%s: all checks matched", name);
		end else begin
			failed_tests++;
			$display("%s: %0d checks mismatched", name, error_count - errors_before);
		end
	endtask

	task automatic run_alu(input alu_op_t op, input logic [31:0] a, input logic [31:0] b);
		logic [63:0] exp;
		exp = expected_z(op, a, b);
		load_gpr(1, a);
		load_gpr(2, b);
		transfer(src_gpr, 1, to_y);
		begin_cycle();
		gpr_out <= `NUM_GPR'(1) << 2;
		z_enable <= 1'b1;
		opcode <= op;
		check_source($sformatf("zlo of %s %h, %h", op.name(), a, b), src_zlo, 0, exp[31:0]);
		check_source($sformatf("zhi of %s %h, %h", op.name(), a, b), src_zhi, 0, exp[63:32]);
	endtask

	task automatic reset_values();
		bus_src_t specials[7] = '{src_hi, src_lo, src_zhi, src_zlo, src_pc, src_mdr, src_inport};
		int e;
		e = error_count;
		check_source("idle bus", src_none, 0, 32'h0);
		for (int i = 0; i < `NUM_GPR; i++) begin
			check_source($sformatf("r%0d after reset", i), src_gpr, i, 32'h0);
		end
		foreach (specials[k]) begin
			check_source($sformatf("%s after reset", specials[k].name()), specials[k], 0, 32'h0);
		end
		finish_test("reset_values", e);
	endtask

	task automatic register_transfer();
		logic [31:0] words[`NUM_GPR];
		logic [31:0] fresh;
		int e;
		e = error_count;
		for (int i = 0; i < `NUM_GPR; i++) begin
			random_word(words[i]);
			load_gpr(i, words[i]);
		end
		for (int i = 0; i < `NUM_GPR; i++) begin
			check_source($sformatf("r%0d readback", i), src_gpr, i, words[i]);
		end
		transfer(src_gpr, 0, to_hi);
		transfer(src_gpr, 1, to_lo); // HI must hold while LO loads
		check_source("hi loaded from r0", src_hi, 0, words[0]);
		check_source("lo loaded from r1", src_lo, 0, words[1]);
		check_source("idle bus with loaded registers", src_none, 0, 32'h0);
		random_word(fresh);
		load_gpr(3, fresh);
		words[3] = fresh; // Only r3 may change
		for (int i = 0; i < `NUM_GPR; i++) begin
			check_source($sformatf("r%0d after r3 reload", i), src_gpr, i, words[i]);
		end
		finish_test("register_transfer", e);
	endtask

	task automatic mdr_loads();
		logic [31:0] m, v;
		int e;
		e = error_count;
		random_word(m);
		random_word(v);
		load_gpr(5, v);
		begin_cycle();
		mem_data_in <= m;
		read <= 1'b1;
		mdr_enable <= 1'b1;
		gpr_out <= `NUM_GPR'(1) << 5; // Bus carries r5 but memory must win
		check_source("mdr after memory read", src_mdr, 0, m);
		transfer(src_gpr, 5, to_mdr);
		check_source("mdr after bus load", src_mdr, 0, v);
		finish_test("mdr", e);
	endtask

	task automatic alu_logic_ops();
		alu_op_t ops[10] = '{op_add, op_sub, op_and, op_or, op_shr, op_shl, op_ror, op_rol,
			op_neg, op_not};
		logic [31:0] a, b;
		int e;
		e = error_count;
		foreach (ops[k]) begin
			repeat (2) begin
				random_word(a);
				random_word(b);
				run_alu(ops[k], a, b);
			end
		end
		run_alu(op_ror, a, 32'd0);
		run_alu(op_rol, a, 32'd31);
		finish_test("alu_logic", e);
	endtask

	task automatic mul_div_ops();
		logic [31:0] a, b;
		int e;
		e = error_count;
		repeat (3) begin
			random_word(a);
			random_word(b);
			run_alu(op_mul, a, b);
			run_alu(op_div, a, b);
		end
		run_alu(op_mul, 32'hffff_fffb, 32'd7);
		run_alu(op_div, 32'hffff_fff9, 32'd2);
		run_alu(op_div, a, 32'd0);
		finish_test("mul_div", e);
	endtask

	task automatic pc_step(input logic [31:0] p);
		load_gpr(7, p);
		transfer(src_gpr, 7, to_pc);
		check_source("pc after load", src_pc, 0, p);
		begin_cycle();
		pc_out <= 1'b1;
		inc_pc <= 1'b1;
		z_enable <= 1'b1;
		opcode <= op_mul; // Increment has to override this
		transfer(src_zlo, 0, to_pc);
		check_source("pc after increment", src_pc, 0, p + 32'd1);
		check_source("zhi after increment", src_zhi, 0, 32'h0);
	endtask

	task automatic pc_increment();
		logic [31:0] p;
		int e;
		e = error_count;
		random_word(p);
		pc_step(p);
		pc_step(32'hffff_ffff);
		finish_test("pc_increment", e);
	endtask

	initial begin
		init_inputs();
		wait (rst === 1'b0);
		reset_values();
		register_transfer();
		mdr_loads();
		alu_logic_ops();
		mul_div_ops();
		pc_increment();
		$display("Tests run: %0d, tests with mismatches: %0d, total mismatches: %0d",
			test_count, failed_tests, error_count);
		if (error_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	initial begin
		#(test_cycles * clk_period + margin_ns);
		$display("Watchdog expired after %0d ns before the tests finished",
			test_cycles * clk_period + margin_ns);
		$display("test failed");
		$finish;
	end

endmodule
